// ==== include/conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Kernel side length, window is K by K
`define CONV_K 3

// Pixel, coefficient and result width
`define CONV_DATA_W 32

// Widest image row the line buffer can hold
`define CONV_MAX_W 16

// Byte address width of the register slave
`define CONV_ADDR_W 8

`endif

// ==== verilog/conv_pkg.sv ====
`default_nettype none

`include "conv_cfg.svh"

package conv_pkg;

    typedef logic [`CONV_DATA_W-1:0] pixel_t;     // One image pixel
    typedef logic [`CONV_DATA_W-1:0] coef_t;      // One filter tap
    typedef logic [`CONV_DATA_W-1:0] acc_t;       // Result, wraps modulo 2^32

    // One image column, index 0 is the oldest row
    typedef logic [`CONV_K*`CONV_DATA_W-1:0] col_t;

    // Flattened K*K sets, index = row*K + column
    typedef logic [`CONV_K*`CONV_K*`CONV_DATA_W-1:0] window_t;
    typedef logic [`CONV_K*`CONV_K*`CONV_DATA_W-1:0] coef_set_t;

    typedef logic [15:0]              dim_t;      // Coordinate or image size
    typedef logic [`CONV_ADDR_W-1:0]  reg_addr_t; // Register byte address

    typedef enum logic [1:0] {
        IDLE,   // Waiting for start
        RUN,    // Taking pixels
        DRAIN   // All pixels in, results still leaving
    } seq_state_t;

    // Register map
    localparam reg_addr_t REG_CTRL        = 'h00; // bit0 start, bit1 clear
    localparam reg_addr_t REG_STATUS      = 'h04; // bit0 busy, bit1 done
    localparam reg_addr_t REG_WIDTH       = 'h08;
    localparam reg_addr_t REG_HEIGHT      = 'h0C;
    localparam reg_addr_t REG_LAST_RESULT = 'h10;
    localparam reg_addr_t REG_COEF_BASE   = 'h20; // One tap every 4 bytes

endpackage

`default_nettype wire

// ==== verilog/conv_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_cfg.svh"

module conv_regfile (
    input  wire                        axi_clk,
    input  wire                        rst_n,
    input  wire conv_pkg::reg_addr_t   s_axi_awaddr,
    input  wire                        s_axi_awvalid,
    output logic                       s_axi_awready,
    input  wire logic [31:0]           s_axi_wdata,
    input  wire                        s_axi_wvalid,
    output logic                       s_axi_wready,
    output logic                       s_axi_bvalid,
    input  wire                        s_axi_bready,
    input  wire conv_pkg::reg_addr_t   s_axi_araddr,
    input  wire                        s_axi_arvalid,
    output logic                       s_axi_arready,
    output logic [31:0]                s_axi_rdata,
    output logic                       s_axi_rvalid,
    input  wire                        s_axi_rready,
    input  wire                        busy,
    input  wire                        frame_done,
    input  wire conv_pkg::acc_t        result,
    input  wire                        result_taken,
    output logic                       frame_start,
    output conv_pkg::dim_t             img_width,
    output conv_pkg::dim_t             img_height,
    output conv_pkg::coef_set_t        coefs
);

    localparam int N  = `CONV_K * `CONV_K;
    localparam int DW = `CONV_DATA_W;

    logic           wr_go;       // AW and W taken together this cycle
    logic           rd_go;
    logic           ctrl_wr;
    logic           done;        // Sticky frame complete flag
    conv_pkg::acc_t last_result;
    logic [31:0]    rd_mux;

    assign wr_go         = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
    assign s_axi_awready = wr_go;
    assign s_axi_wready  = wr_go;
    assign s_axi_arready = !s_axi_rvalid;  // One read outstanding at most
    assign rd_go         = s_axi_arvalid && s_axi_arready;
    assign ctrl_wr       = wr_go && (s_axi_awaddr == conv_pkg::REG_CTRL);

    // Write response
    always_ff @(posedge axi_clk) begin
        if (!rst_n) begin
            s_axi_bvalid <= 1'b0;
        end else if (wr_go) begin
            s_axi_bvalid <= 1'b1;
        end else if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
        end
    end

    // Config registers and start pulse
    always_ff @(posedge axi_clk) begin
        if (!rst_n) begin
            frame_start <= 1'b0;
            img_width   <= '0;
            img_height  <= '0;
            coefs       <= '0;
            last_result <= '0;
        end else begin
            frame_start <= ctrl_wr && s_axi_wdata[0];
            if (wr_go && s_axi_awaddr == conv_pkg::REG_WIDTH)  img_width  <= s_axi_wdata[15:0];
            if (wr_go && s_axi_awaddr == conv_pkg::REG_HEIGHT) img_height <= s_axi_wdata[15:0];
            for (int i = 0; i < N; i++) begin
                if (wr_go && s_axi_awaddr == conv_pkg::reg_addr_t'(conv_pkg::REG_COEF_BASE + 4 * i))
                    coefs[i*DW +: DW] <= s_axi_wdata;
            end
            if (result_taken) last_result <= result;  // Every output beat
            if (ctrl_wr && s_axi_wdata[1]) begin      // Clear wins over the rest
                img_width   <= '0;
                img_height  <= '0;
                coefs       <= '0;
                last_result <= '0;
            end
        end
    end

    always_ff @(posedge axi_clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (frame_start) begin
            done <= 1'b0;  // New frame drops the old completion
        end else if (frame_done) begin
            done <= 1'b1;
        end
    end

    always_comb begin
        rd_mux = '0;  // CTRL and holes read zero
        case (s_axi_araddr)
            conv_pkg::REG_STATUS:      rd_mux = {30'd0, done, busy};
            conv_pkg::REG_WIDTH:       rd_mux = {16'd0, img_width};
            conv_pkg::REG_HEIGHT:      rd_mux = {16'd0, img_height};
            conv_pkg::REG_LAST_RESULT: rd_mux = last_result;
            default:                   rd_mux = '0;
        endcase
        for (int i = 0; i < N; i++) begin
            if (s_axi_araddr == conv_pkg::reg_addr_t'(conv_pkg::REG_COEF_BASE + 4 * i))
                rd_mux = coefs[i*DW +: DW];
        end
    end

    // Read response, data registered with the address handshake
    always_ff @(posedge axi_clk) begin
        if (!rst_n) begin
            s_axi_rvalid <= 1'b0;
        end else if (rd_go) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (rd_go) s_axi_rdata <= rd_mux;
    end

endmodule

`default_nettype wire

// ==== verilog/line_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_cfg.svh"

module line_buffer (
    input  wire                    axi_clk,
    input  wire                    rst_n,
    input  wire conv_pkg::pixel_t  pix,
    input  wire                    pix_wr,
    input  wire conv_pkg::dim_t    col_x,
    input  wire                    hold,
    output conv_pkg::col_t         column
);

    localparam int K  = `CONV_K;
    localparam int DW = `CONV_DATA_W;
    localparam int XW = $clog2(`CONV_MAX_W);
    localparam int RW = (K > 1) ? $clog2(K) : 1;

    conv_pkg::pixel_t mem [K][`CONV_MAX_W];  // One memory per kept row

    logic [RW-1:0] row_ptr;    // Row being filled
    logic [RW-1:0] cur_row;
    logic [RW-1:0] rd_row [K]; // Physical row for each column slot
    logic [XW-1:0] wr_x;
    logic [XW-1:0] last_x;     // Column of the previous pixel
    logic          new_row;

    assign wr_x = col_x[XW-1:0];

    // Column 0 after a non-zero column means the sequencer wrapped a row
    assign new_row = pix_wr && (wr_x == '0) && (last_x != '0);
    assign cur_row = !new_row ? row_ptr :
                     (row_ptr == RW'(K - 1)) ? '0 : row_ptr + 1'b1;

    always_comb begin
        for (int i = 0; i < K; i++) begin
            rd_row[i] = RW'((int'(cur_row) + 1 + i) % K);  // Oldest first, newest last
        end
    end

    always_ff @(posedge axi_clk) begin
        if (!rst_n) begin
            row_ptr <= '0;
            last_x  <= '0;
        end else if (pix_wr) begin
            row_ptr <= cur_row;
            last_x  <= wr_x;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (pix_wr) mem[cur_row][wr_x] <= pix;
    end

    // Newest slot bypasses the memory so the fresh pixel shows at once
    always_ff @(posedge axi_clk) begin
        if (!hold) begin
            for (int i = 0; i < K; i++) begin
                column[i*DW +: DW] <= (i == K - 1 && pix_wr) ? pix : mem[rd_row[i]][wr_x];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/window_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_cfg.svh"

module window_sequencer (
    input  wire                    axi_clk,
    input  wire                    rst_n,
    input  wire                    frame_start,
    input  wire conv_pkg::dim_t    img_width,
    input  wire conv_pkg::dim_t    img_height,
    input  wire                    s_axis_valid,
    output logic                   s_axis_ready,
    input  wire conv_pkg::col_t    column,
    input  wire                    pipe_advance,
    input  wire                    frame_out_done,
    output logic                   pix_wr,
    output conv_pkg::dim_t         col_x,
    output conv_pkg::window_t      window,
    output logic                   mac_start,
    output logic                   mac_last,
    output logic                   busy,
    output logic                   frame_done
);

    localparam int K  = `CONV_K;
    localparam int DW = `CONV_DATA_W;

    conv_pkg::seq_state_t state;
    conv_pkg::dim_t       x;          // Column of the next pixel
    conv_pkg::dim_t       y;          // Row of the next pixel
    logic                 last_col;
    logic                 last_row;
    logic                 col_valid;  // Line buffer column is fresh
    logic                 col_pos;    // That column closes a valid window
    logic                 col_last;   // That column closes the final window

    assign busy         = (state != conv_pkg::IDLE);
    assign s_axis_ready = (state == conv_pkg::RUN) && pipe_advance;
    assign pix_wr       = s_axis_valid && s_axis_ready;
    assign col_x        = x;
    assign last_col     = (x == img_width - 16'd1);
    assign last_row     = (y == img_height - 16'd1);

    always_ff @(posedge axi_clk) begin
        if (!rst_n) begin
            state      <= conv_pkg::IDLE;
            x          <= '0;
            y          <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                conv_pkg::IDLE: begin
                    if (frame_start) begin
                        x     <= '0;
                        y     <= '0;
                        state <= conv_pkg::RUN;
                    end
                end
                conv_pkg::RUN: begin
                    if (pix_wr) begin
                        if (last_col) begin
                            x <= '0;  // Wrap tells the line buffer a row ended
                            if (last_row) state <= conv_pkg::DRAIN;
                            else          y     <= y + 16'd1;
                        end else begin
                            x <= x + 16'd1;
                        end
                    end
                end
                conv_pkg::DRAIN: begin
                    if (frame_out_done) begin  // Last beat left the MAC
                        state      <= conv_pkg::IDLE;
                        frame_done <= 1'b1;
                    end
                end
                default: state <= conv_pkg::IDLE;
            endcase
        end
    end

    // Position flags trail the pixel by one cycle to meet the column
    always_ff @(posedge axi_clk) begin
        if (!rst_n) begin
            col_valid <= 1'b0;
            col_pos   <= 1'b0;
            col_last  <= 1'b0;
            mac_start <= 1'b0;
            mac_last  <= 1'b0;
        end else if (pipe_advance) begin
            col_valid <= pix_wr;
            col_pos   <= pix_wr && (x >= 16'(K - 1)) && (y >= 16'(K - 1));
            col_last  <= pix_wr && last_col && last_row;
            mac_start <= col_pos;
            mac_last  <= col_last;
        end
    end

    // Shift left by one column, new column enters on the right
    always_ff @(posedge axi_clk) begin
        if (pipe_advance && col_valid) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    window[(r*K + c)*DW +: DW] <= window[(r*K + c + 1)*DW +: DW];
                end
                window[(r*K + K - 1)*DW +: DW] <= column[r*DW +: DW];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mac_array.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_cfg.svh"

module mac_array (
    input  wire                        axi_clk,
    input  wire                        rst_n,
    input  wire conv_pkg::window_t     window,
    input  wire conv_pkg::coef_set_t   coefs,
    input  wire                        mac_start,
    input  wire                        mac_last,
    input  wire                        m_axis_ready,
    output conv_pkg::acc_t             m_axis_data,
    output logic                       m_axis_valid,
    output logic                       m_axis_last,
    output logic                       pipe_advance,
    output logic                       frame_out_done
);

    localparam int N  = `CONV_K * `CONV_K;
    localparam int DW = `CONV_DATA_W;
    localparam int NP = 1 << $clog2(N);  // Leaves padded to a power of two

    conv_pkg::pixel_t win_px [N];
    conv_pkg::coef_t  win_cf [N];
    conv_pkg::acc_t   prod   [N];          // Stage 1 products
    conv_pkg::acc_t   node   [1:2*NP-1];   // Adder tree, node 1 is the root
    logic             s1_valid;
    logic             s1_last;

    assign pipe_advance   = !m_axis_valid || m_axis_ready;  // Output empty or draining
    assign frame_out_done = m_axis_valid && m_axis_ready && m_axis_last;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            win_px[i] = window[i*DW +: DW];
            win_cf[i] = coefs[i*DW +: DW];
        end
    end

    always_ff @(posedge axi_clk) begin
        if (pipe_advance && mac_start) begin
            for (int i = 0; i < N; i++) begin
                prod[i] <= conv_pkg::acc_t'(win_px[i] * win_cf[i]);  // Low 32 bits only
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NP; i++) begin
            node[NP + i] = (i < N) ? prod[i] : '0;
        end
        for (int i = NP - 1; i >= 1; i--) begin
            node[i] = node[2*i] + node[2*i + 1];
        end
    end

    always_ff @(posedge axi_clk) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            s1_last      <= 1'b0;
            m_axis_valid <= 1'b0;
            m_axis_last  <= 1'b0;
        end else if (pipe_advance) begin
            s1_valid     <= mac_start;
            s1_last      <= mac_start && mac_last;
            m_axis_valid <= s1_valid;
            m_axis_last  <= s1_last;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (pipe_advance && s1_valid) m_axis_data <= node[1];
    end

endmodule

`default_nettype wire

// ==== verilog/conv_accel_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_cfg.svh"

module conv_accel_top (
    input  wire                        axi_clk,
    input  wire                        rst_n,
    // Register slave
    input  wire conv_pkg::reg_addr_t   s_axi_awaddr,
    input  wire                        s_axi_awvalid,
    output logic                       s_axi_awready,
    input  wire logic [31:0]           s_axi_wdata,
    input  wire                        s_axi_wvalid,
    output logic                       s_axi_wready,
    output logic                       s_axi_bvalid,
    input  wire                        s_axi_bready,
    input  wire conv_pkg::reg_addr_t   s_axi_araddr,
    input  wire                        s_axi_arvalid,
    output logic                       s_axi_arready,
    output logic [31:0]                s_axi_rdata,
    output logic                       s_axi_rvalid,
    input  wire                        s_axi_rready,
    // Pixel stream in
    input  wire conv_pkg::pixel_t      s_axis_data,
    input  wire                        s_axis_valid,
    output logic                       s_axis_ready,
    input  wire                        s_axis_last,   // Frame length comes from WIDTH and HEIGHT
    // Result stream out
    output conv_pkg::acc_t             m_axis_data,
    output logic                       m_axis_valid,
    input  wire                        m_axis_ready,
    output logic                       m_axis_last
);

    logic                frame_start;
    logic                frame_done;
    logic                busy;
    conv_pkg::dim_t      img_width;
    conv_pkg::dim_t      img_height;
    conv_pkg::coef_set_t coefs;
    logic                pix_wr;
    conv_pkg::dim_t      col_x;
    conv_pkg::col_t      column;
    conv_pkg::window_t   window;
    logic                mac_start;
    logic                mac_last;
    logic                pipe_advance;
    logic                frame_out_done;
    logic                result_taken;

    assign result_taken = m_axis_valid && m_axis_ready;  // Output beat accepted

    conv_regfile u_regfile (
        .result (m_axis_data),
        .*
    );

    window_sequencer u_sequencer (.*);

    line_buffer u_line_buffer (
        .pix  (s_axis_data),
        .hold (!pipe_advance),  // Freeze with the rest of the pipe
        .*
    );

    mac_array u_mac (.*);

endmodule

`default_nettype wire

// ==== sim/conv_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_assertions (
    input wire                  axi_clk,
    input wire                  rst_n,
    input wire conv_pkg::acc_t  m_axis_data,
    input wire                  m_axis_valid,
    input wire                  m_axis_ready,
    input wire                  s_axis_ready,
    input wire                  s_axi_bvalid,
    input wire                  s_axi_bready,
    input wire                  s_axi_rvalid,
    input wire                  s_axi_rready
);

    int fail_count = 0;  // Watched by the testbench

    // Stalled output beat must not move
    property stream_hold;
        @(posedge axi_clk) disable iff (!rst_n)
        m_axis_valid && !m_axis_ready |=> m_axis_valid && $stable(m_axis_data);
    endproperty

    property bresp_hold;
        @(posedge axi_clk) disable iff (!rst_n)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid;
    endproperty

    property rresp_hold;
        @(posedge axi_clk) disable iff (!rst_n)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid;
    endproperty

    // First cycle out of reset, both streams idle
    property quiet_after_reset;
        @(posedge axi_clk) $rose(rst_n) |-> !m_axis_valid && !s_axis_ready;
    endproperty

    a_stream_hold: assert property (stream_hold) else begin
        $error("m_axis beat changed or dropped while m_axis_ready was low");
        fail_count++;
    end
    a_bresp_hold: assert property (bresp_hold) else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end
    a_rresp_hold: assert property (rresp_hold) else begin
        $error("rvalid dropped before rready");
        fail_count++;
    end
    a_quiet_after_reset: assert property (quiet_after_reset) else begin
        $error("stream valid or ready high right after reset");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== sim/conv_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_cfg.svh"

module conv_tb;

    localparam int K           = `CONV_K;
    localparam int DRIVE_DLY   = 2;            // ns after the rising edge
    localparam int STATUS_POLLS = 50;
    localparam logic [31:0] RAND_SEED = 32'h69a8d075;
    // Pixels plus results of every frame, 4 cycles each, plus slack
    localparam int WATCHDOG_CYCLES = 4 * ((16 + 4) + 3 * (30 + 12)) + 2000;

    logic                axi_clk;
    logic                rst_n;
    conv_pkg::reg_addr_t s_axi_awaddr;
    logic                s_axi_awvalid;
    logic                s_axi_awready;
    logic [31:0]         s_axi_wdata;
    logic                s_axi_wvalid;
    logic                s_axi_wready;
    logic                s_axi_bvalid;
    logic                s_axi_bready;
    conv_pkg::reg_addr_t s_axi_araddr;
    logic                s_axi_arvalid;
    logic                s_axi_arready;
    logic [31:0]         s_axi_rdata;
    logic                s_axi_rvalid;
    logic                s_axi_rready;
    conv_pkg::pixel_t    s_axis_data;
    logic                s_axis_valid;
    logic                s_axis_ready;
    logic                s_axis_last;
    conv_pkg::acc_t      m_axis_data;
    logic                m_axis_valid;
    logic                m_axis_ready;
    logic                m_axis_last;

    // Current frame and its expected output
    int          frame_w;
    int          frame_h;
    logic [31:0] frame_pix [$];   // Raster order
    logic [31:0] frame_coef [K*K];
    logic [31:0] expected [$];
    logic [31:0] got_data [$];
    logic        got_last [$];

    conv_accel_top uut (
        .axi_clk(axi_clk), .rst_n(rst_n),
        .s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
        .s_axi_awready(s_axi_awready), .s_axi_wdata(s_axi_wdata),
        .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
        .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
        .s_axi_araddr(s_axi_araddr), .s_axi_arvalid(s_axi_arvalid),
        .s_axi_arready(s_axi_arready), .s_axi_rdata(s_axi_rdata),
        .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
        .s_axis_data(s_axis_data), .s_axis_valid(s_axis_valid),
        .s_axis_ready(s_axis_ready), .s_axis_last(s_axis_last),
        .m_axis_data(m_axis_data), .m_axis_valid(m_axis_valid),
        .m_axis_ready(m_axis_ready), .m_axis_last(m_axis_last)
    );

    bind conv_accel_top conv_assertions u_assert (.*);

    initial begin
        axi_clk = 1'b0;
        forever #20 axi_clk = ~axi_clk;  // 40 ns period
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("FAILED at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    function automatic conv_pkg::reg_addr_t coef_addr(input int i);
        return conv_pkg::reg_addr_t'(conv_pkg::REG_COEF_BASE + 4 * i);
    endfunction

    task automatic axi_write(input conv_pkg::reg_addr_t addr, input logic [31:0] data);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        do begin
            @(posedge axi_clk);
        end while (!(s_axi_awready && s_axi_wready));
        #DRIVE_DLY;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        @(posedge axi_clk);  // Response waits one cycle with bready low
        #DRIVE_DLY;
        s_axi_bready  = 1'b1;
        do begin
            @(posedge axi_clk);
        end while (!s_axi_bvalid);  // Response taken on this edge
        #DRIVE_DLY;
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input conv_pkg::reg_addr_t addr, output logic [31:0] data);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        do begin
            @(posedge axi_clk);
        end while (!s_axi_arready);
        #DRIVE_DLY;
        s_axi_arvalid = 1'b0;
        @(posedge axi_clk);  // Read data waits one cycle with rready low
        #DRIVE_DLY;
        s_axi_rready  = 1'b1;
        do begin
            @(posedge axi_clk);
        end while (!s_axi_rvalid);
        data = s_axi_rdata;
        #DRIVE_DLY;
        s_axi_rready = 1'b0;
    endtask

    // Valid convolution, sums wrap at 32 bits
    task automatic compute_reference();
        logic [31:0] acc;
        expected.delete();
        for (int oy = 0; oy <= frame_h - K; oy++) begin
            for (int ox = 0; ox <= frame_w - K; ox++) begin
                acc = '0;
                for (int r = 0; r < K; r++) begin
                    for (int c = 0; c < K; c++) begin
                        acc = acc + frame_pix[(oy + r) * frame_w + ox + c] * frame_coef[r*K + c];
                    end
                end
                expected.push_back(acc);
            end
        end
    endtask

    task automatic send_frame(input bit gaps);
        int idle;
        for (int i = 0; i < frame_pix.size(); i++) begin
            idle = gaps ? $urandom_range(2, 0) : 0;
            if (idle > 0) begin
                s_axis_valid = 1'b0;  // Source bubble
                repeat (idle) @(posedge axi_clk);
                #DRIVE_DLY;
            end
            s_axis_data  = frame_pix[i];
            s_axis_last  = (i == frame_pix.size() - 1);
            s_axis_valid = 1'b1;
            do begin
                @(posedge axi_clk);
            end while (!s_axis_ready);
            #DRIVE_DLY;
        end
        s_axis_valid = 1'b0;
        s_axis_last  = 1'b0;
    endtask

    task automatic collect_frame(input int n, input bit gaps);
        int idle;
        got_data.delete();
        got_last.delete();
        for (int i = 0; i < n; i++) begin
            idle = gaps ? $urandom_range(2, 0) : 0;
            if (idle > 0) begin
                m_axis_ready = 1'b0;  // Sink back-pressure
                repeat (idle) @(posedge axi_clk);
                #DRIVE_DLY;
            end
            m_axis_ready = 1'b1;
            do begin
                @(posedge axi_clk);
            end while (!m_axis_valid);
            got_data.push_back(m_axis_data);
            got_last.push_back(m_axis_last);
            #DRIVE_DLY;
        end
        m_axis_ready = 1'b0;  // A surplus beat stays visible on the port
    endtask

    // Poll until the sticky done bit shows up
    task automatic wait_frame_done();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[1]) begin
            if (polls == STATUS_POLLS) abort_run("STATUS never reported done after the frame");
            axi_read(conv_pkg::REG_STATUS, status);
            polls++;
        end
        check_value("STATUS after frame", status, 32'h2);  // busy low, done high
    endtask

    task automatic load_frame_config();
        axi_write(conv_pkg::REG_WIDTH, 32'(frame_w));
        axi_write(conv_pkg::REG_HEIGHT, 32'(frame_h));
        for (int i = 0; i < K*K; i++) begin
            axi_write(coef_addr(i), frame_coef[i]);
        end
    endtask

    task automatic stream_frame(input bit gaps);
        fork
            send_frame(gaps);
            collect_frame(expected.size(), gaps);
        join
        foreach (expected[i]) begin
            check_value($sformatf("result %0d", i), got_data[i], expected[i]);
            check_value($sformatf("last flag of result %0d", i), got_last[i],
                        i == expected.size() - 1);
        end
        wait_frame_done();
        check_value("m_axis_valid after frame", m_axis_valid, 1'b0);  // No extra beat
    endtask

    task automatic run_frame(input bit gaps);
        axi_write(conv_pkg::REG_CTRL, 32'h1);  // Start
        stream_frame(gaps);
    endtask

    task automatic make_random_frame(input int w, input int h);
        frame_w = w;
        frame_h = h;
        frame_pix.delete();
        for (int i = 0; i < w * h; i++) frame_pix.push_back($urandom);
        foreach (frame_coef[i]) frame_coef[i] = $urandom;
    endtask

    task automatic register_readback();
        logic [31:0] rd;
        logic [15:0] w;
        logic [15:0] h;
        logic [31:0] cf [K*K];
        w = 16'($urandom);
        h = 16'($urandom);
        foreach (cf[i]) cf[i] = $urandom;
        axi_write(conv_pkg::REG_WIDTH, {16'd0, w});
        axi_write(conv_pkg::REG_HEIGHT, {16'd0, h});
        foreach (cf[i]) axi_write(coef_addr(i), cf[i]);
        axi_read(conv_pkg::REG_WIDTH, rd);
        check_value("WIDTH", rd, {16'd0, w});
        axi_read(conv_pkg::REG_HEIGHT, rd);
        check_value("HEIGHT", rd, {16'd0, h});
        foreach (cf[i]) begin
            axi_read(coef_addr(i), rd);
            check_value($sformatf("COEF %0d", i), rd, cf[i]);
        end
        axi_write(conv_pkg::REG_CTRL, 32'h2);  // Clear everything
        axi_read(conv_pkg::REG_WIDTH, rd);
        check_value("WIDTH after clear", rd, '0);
        axi_read(conv_pkg::REG_HEIGHT, rd);
        check_value("HEIGHT after clear", rd, '0);
        foreach (cf[i]) begin
            axi_read(coef_addr(i), rd);
            check_value($sformatf("COEF %0d after clear", i), rd, '0);
        end
    endtask

    // Centre tap only, output is the inner part of the ramp
    task automatic identity_kernel();
        frame_w = 4;
        frame_h = 4;
        frame_pix.delete();
        for (int i = 0; i < 16; i++) frame_pix.push_back(i + 1);
        foreach (frame_coef[i]) frame_coef[i] = '0;
        frame_coef[(K/2) * K + K/2] = 32'd1;
        expected.delete();
        for (int oy = 0; oy <= frame_h - K; oy++) begin
            for (int ox = 0; ox <= frame_w - K; ox++) begin
                expected.push_back(frame_pix[(oy + K/2) * frame_w + ox + K/2]);
            end
        end
        load_frame_config();
        run_frame(1'b0);
    endtask

    task automatic random_frame();
        make_random_frame(6, 5);
        compute_reference();
        load_frame_config();
        run_frame(1'b0);
    endtask

    task automatic back_pressure();
        run_frame(1'b1);  // Same frame, random gaps on both streams
    endtask

    task automatic completion_status();
        logic [31:0] rd;
        axi_read(conv_pkg::REG_STATUS, rd);
        check_value("STATUS when idle", rd, 32'h2);
        axi_read(conv_pkg::REG_LAST_RESULT, rd);
        check_value("LAST_RESULT", rd, expected[expected.size() - 1]);
        axi_write(conv_pkg::REG_CTRL, 32'h1);
        axi_read(conv_pkg::REG_STATUS, rd);
        check_value("STATUS while running", rd, 32'h1);  // done dropped by start
        stream_frame(1'b0);
        axi_write(conv_pkg::REG_CTRL, 32'h2);  // Clear drops the held result
        axi_read(conv_pkg::REG_LAST_RESULT, rd);
        check_value("LAST_RESULT after clear", rd, '0);
    endtask

    // Stop as soon as a bound assertion has fired
    always @(posedge axi_clk) begin
        if (uut.u_assert.fail_count != 0) abort_run("A protocol assertion on the DUT fired");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge axi_clk);
        abort_run($sformatf("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(RAND_SEED));
        rst_n         = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        s_axis_data   = '0;
        s_axis_valid  = 1'b0;
        s_axis_last   = 1'b0;
        m_axis_ready  = 1'b0;
        repeat (16) @(posedge axi_clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        repeat (2) @(posedge axi_clk);
        #DRIVE_DLY;
        register_readback();
        identity_kernel();
        random_frame();
        back_pressure();
        completion_status();
        if (uut.u_assert.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run("A protocol assertion on the DUT fired");
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
verilog/conv_pkg.sv
verilog/conv_regfile.sv
verilog/line_buffer.sv
verilog/window_sequencer.sv
verilog/mac_array.sv
verilog/conv_accel_top.sv
sim/conv_assertions.sv
sim/conv_tb.sv

// ==== Bender.yml ====
package:
  name: conv_accel

export_include_dirs:
  - include

sources:
  - files:
      - verilog/conv_pkg.sv
      - verilog/conv_regfile.sv
      - verilog/line_buffer.sv
      - verilog/window_sequencer.sv
      - verilog/mac_array.sv
      - verilog/conv_accel_top.sv
  - target: simulation
    files:
      - sim/conv_assertions.sv
      - sim/conv_tb.sv
